// File: verilog/pdp8_pkg.sv
// PDP-8 core definitions
package pdp8_pkg;

    typedef logic [11:0] word_t;

    // memory reference view.
    typedef struct packed {
        logic [2:0] opcode;
        logic       indirect;
        logic       page;
        logic [6:0] offset;
    } mri_t;

    // operate view, group 0 is group 1 in PDP-8 terms.
    typedef struct packed {
        logic [2:0] opcode;
        logic       group;
        logic [7:0] micro;
    } opr_t;

    typedef union packed {
        mri_t mri;
        opr_t opr;
    } instr_u;

    localparam logic [2:0] op_and = 3'd0;
    localparam logic [2:0] op_tad = 3'd1;
    localparam logic [2:0] op_isz = 3'd2;
    localparam logic [2:0] op_dca = 3'd3;
    localparam logic [2:0] op_jms = 3'd4;
    localparam logic [2:0] op_jmp = 3'd5;
    localparam logic [2:0] op_iot = 3'd6;
    localparam logic [2:0] op_opr = 3'd7;

    // micro-op bit positions within opr_t.micro.
    localparam int ub_cla = 7;
    localparam int ub_cll = 6;
    localparam int ub_cma = 5;
    localparam int ub_cml = 4;
    localparam int ub_rar = 3;
    localparam int ub_ral = 2;
    localparam int ub_iac = 0;
    localparam int ub_sma = 6;
    localparam int ub_sza = 5;
    localparam int ub_snl = 4;
    localparam int ub_rev = 3;
    localparam int ub_hlt = 1;

    typedef enum logic [1:0] {
        st_halt  = 2'd0,
        st_fetch = 2'd1,
        st_defer = 2'd2,
        st_exec  = 2'd3
    } state_t;

    localparam logic [3:0] reg_ctrl = 4'h0;
    localparam logic [3:0] reg_addr = 4'h4;
    localparam logic [3:0] reg_data = 4'h8;
    localparam logic [3:0] reg_ac   = 4'hC;

endpackage

// File: verilog/core_bus_if.sv
// PDP-8 core bus
`timescale 1ns/1ps

interface core_bus_if import pdp8_pkg::*; ();

    state_t state;
    instr_u ir;
    word_t  mdout;
    word_t  ma;
    word_t  ac;
    logic   link;
    logic   skip;
    logic   mem_we;
    word_t  mem_wdata;

    modport ctrl (input mdout, output state, output ir);

    modport addr (input state, input ir, input mdout, input skip, output ma);

    modport alu (input state, input ir, input mdout, input ma,
                 output ac, output link, output skip, output mem_we, output mem_wdata);

    modport mem (input ma, input mem_we, input mem_wdata, output mdout);

endinterface

// File: verilog/state_machine.sv
// PDP-8 major state control
`timescale 1ns/1ps

module state_machine import pdp8_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    core_bus_if.ctrl bus,
    input  logic   start,
    input  logic   halt_req,
    output logic   running
);

    state_t state_q;
    state_t state_d;
    instr_u ir_q;
    instr_u fetched;
    logic   halt_pend;
    logic   is_hlt;
    logic   needs_defer;

    assign fetched = bus.mdout;

    // only memory references take the indirect path.
    assign needs_defer = (fetched.mri.opcode < op_iot) && fetched.mri.indirect;

    assign is_hlt = (ir_q.opr.opcode == op_opr) && ir_q.opr.group && ir_q.opr.micro[ub_hlt];

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_halt:
            begin
                if (start)
                    state_d = st_fetch;
            end
            st_fetch:
            begin
                state_d = needs_defer ? st_defer : st_exec;
            end
            st_defer:
            begin
                state_d = st_exec;
            end
            st_exec:
            begin
                // a halt takes effect only once the instruction is done.
                if (is_hlt || halt_pend || halt_req)
                    state_d = st_halt;
                else
                    state_d = st_fetch;
            end
            default:
            begin
                state_d = st_halt;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q   <= st_halt;
            halt_pend <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_d == st_halt)
                halt_pend <= 1'b0;
            else if (halt_req)
                halt_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == st_fetch)
            ir_q <= fetched;
    end

    assign bus.state = state_q;
    assign bus.ir    = ir_q;
    assign running   = (state_q != st_halt);

endmodule

// File: verilog/ma_pc.sv
// program counter and memory address
`timescale 1ns/1ps

module ma_pc import pdp8_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    core_bus_if.addr bus,
    input  logic   pc_load,
    input  word_t  pc_value
);

    word_t  pc_q;
    word_t  ma_q;
    word_t  ea;
    instr_u fetched;

    assign fetched = bus.mdout;

    // page bit picks the current page of the instruction or page zero.
    assign ea = fetched.mri.page ? {pc_q[11:7], fetched.mri.offset}
                                 : {5'b0, fetched.mri.offset};

    // during fetch the memory sees the PC directly.
    assign bus.ma = (bus.state == st_fetch) ? pc_q : ma_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_q <= '0;
        end
        else if (pc_load)
        begin
            pc_q <= pc_value;
        end
        else if (bus.state == st_fetch)
        begin
            pc_q <= pc_q + 12'd1;
        end
        else if (bus.state == st_exec)
        begin
            if (bus.ir.mri.opcode == op_jmp)
                pc_q <= ma_q;
            else if (bus.ir.mri.opcode == op_jms)
                pc_q <= ma_q + 12'd1;
            else if (bus.skip)
                pc_q <= pc_q + 12'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        case (bus.state)
            st_fetch:
                ma_q <= ea;
            st_defer:
                ma_q <= bus.mdout;
            default:
                ma_q <= ma_q;
        endcase
    end

endmodule

// File: verilog/ac_link.sv
// accumulator and link
`timescale 1ns/1ps

module ac_link import pdp8_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    core_bus_if.alu bus
);

    word_t       ac_q;
    logic        link_q;
    word_t       ret_addr;
    word_t       inc_data;
    logic [12:0] tad_sum;
    word_t       opr_ac;
    logic        opr_link;
    logic        iac_carry;
    logic        g2_cond;
    logic        g2_skip;
    logic [7:0]  micro;
    logic        in_exec;

    assign micro    = bus.ir.opr.micro;
    assign in_exec  = (bus.state == st_exec);
    assign inc_data = bus.mdout + 12'd1;
    assign tad_sum  = {1'b0, ac_q} + {1'b0, bus.mdout};

    // group 1 runs clear, complement, rotate, increment.
    always_comb
    begin
        opr_ac    = ac_q;
        opr_link  = link_q;
        iac_carry = 1'b0;
        g2_cond   = 1'b0;
        g2_skip   = 1'b0;
        if (!bus.ir.opr.group)
        begin
            if (micro[ub_cla])
                opr_ac = '0;
            if (micro[ub_cll])
                opr_link = 1'b0;
            if (micro[ub_cma])
                opr_ac = ~opr_ac;
            if (micro[ub_cml])
                opr_link = ~opr_link;
            if (micro[ub_rar])
                {opr_link, opr_ac} = {opr_ac[0], opr_link, opr_ac[11:1]};
            else if (micro[ub_ral])
                {opr_link, opr_ac} = {opr_ac, opr_link};
            if (micro[ub_iac])
            begin
                {iac_carry, opr_ac} = {1'b0, opr_ac} + 13'd1;
                opr_link = opr_link ^ iac_carry;
            end
        end
        else
        begin
            g2_cond = (micro[ub_sma] & ac_q[11]) |
                      (micro[ub_sza] & (ac_q == 12'd0)) |
                      (micro[ub_snl] & link_q);
            // reversed sense skips only when every selected test fails.
            g2_skip = micro[ub_rev] ? ~g2_cond : g2_cond;
            if (micro[ub_cla])
                opr_ac = '0;
        end
    end

    always_comb
    begin
        bus.skip      = 1'b0;
        bus.mem_we    = 1'b0;
        bus.mem_wdata = ac_q;
        if (in_exec)
        begin
            case (bus.ir.mri.opcode)
                op_isz:
                begin
                    bus.skip      = (inc_data == 12'd0);
                    bus.mem_we    = 1'b1;
                    bus.mem_wdata = inc_data;
                end
                op_dca:
                begin
                    bus.mem_we = 1'b1;
                end
                op_jms:
                begin
                    bus.mem_we    = 1'b1;
                    bus.mem_wdata = ret_addr;
                end
                op_opr:
                begin
                    bus.skip = g2_skip;
                end
                default:
                begin
                    bus.skip = 1'b0;
                end
            endcase
        end
    end

    // ma carries the PC during fetch, so this is the return address.
    always_ff @(posedge clk)
    begin
        if (bus.state == st_fetch)
            ret_addr <= bus.ma + 12'd1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ac_q   <= '0;
            link_q <= 1'b0;
        end
        else if (in_exec)
        begin
            case (bus.ir.mri.opcode)
                op_and:
                    ac_q <= ac_q & bus.mdout;
                op_tad:
                begin
                    ac_q   <= tad_sum[11:0];
                    link_q <= link_q ^ tad_sum[12];
                end
                op_dca:
                    ac_q <= '0;
                op_opr:
                begin
                    ac_q   <= opr_ac;
                    link_q <= opr_link;
                end
                default:
                    ac_q <= ac_q;
            endcase
        end
    end

    assign bus.ac   = ac_q;
    assign bus.link = link_q;

endmodule

// File: verilog/core_mem.sv
// 4K word core memory
`timescale 1ns/1ps

module core_mem import pdp8_pkg::*; (
    input  logic  clk,
    core_bus_if.mem bus,
    input  word_t panel_addr,
    input  logic  panel_we,
    input  word_t panel_wdata,
    output word_t panel_rdata
);

    word_t mem [0:4095];

    assign bus.mdout   = mem[bus.ma];
    assign panel_rdata = mem[panel_addr];

    // panel writes only arrive while the core is halted.
    always_ff @(posedge clk)
    begin
        if (bus.mem_we)
            mem[bus.ma] <= bus.mem_wdata;
        else if (panel_we)
            mem[panel_addr] <= panel_wdata;
    end

endmodule

// File: verilog/front_panel_apb.sv
// APB front panel
`timescale 1ns/1ps

module front_panel_apb import pdp8_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        running,
    input  word_t       ac,
    input  logic        link,
    output logic        start,
    output logic        halt_req,
    output logic        pc_load,
    output word_t       pc_value,
    output word_t       panel_addr,
    output logic        panel_we,
    output word_t       panel_wdata,
    input  word_t       panel_rdata
);

    word_t addr_q;
    logic  access;
    logic  wr;
    logic  busy_reg;

    assign access = psel & penable;
    assign wr     = access & pwrite;

    // address and data registers belong to the core while it runs.
    assign busy_reg = running & ((paddr == reg_addr) | (paddr == reg_data));

    assign pready  = 1'b1;
    assign pslverr = access & busy_reg;

    assign start       = wr & (paddr == reg_ctrl) & pwdata[0];
    assign halt_req    = wr & (paddr == reg_ctrl) & pwdata[1];
    assign pc_load     = wr & (paddr == reg_addr) & ~running;
    assign pc_value    = pwdata[11:0];
    assign panel_we    = wr & (paddr == reg_data) & ~running;
    assign panel_wdata = pwdata[11:0];
    assign panel_addr  = addr_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            addr_q <= '0;
        else if (pc_load)
            addr_q <= pwdata[11:0];
        else if (panel_we)
            addr_q <= addr_q + 12'd1;
    end

    always_comb
    begin
        prdata = '0;
        case (paddr)
            reg_ctrl:
                prdata[0] = running;
            reg_data:
            begin
                if (!running)
                    prdata[11:0] = panel_rdata;
            end
            reg_ac:
                prdata[12:0] = {link, ac};
            default:
                prdata = '0;
        endcase
    end

endmodule

// File: verilog/pdp8_top.sv
// PDP-8 core with APB panel
`timescale 1ns/1ps

module pdp8_top import pdp8_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic  start;
    logic  halt_req;
    logic  running;
    logic  pc_load;
    word_t pc_value;
    word_t panel_addr;
    logic  panel_we;
    word_t panel_wdata;
    word_t panel_rdata;

    core_bus_if bus ();

    state_machine i_state_machine (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus.ctrl),
        .start    (start),
        .halt_req (halt_req),
        .running  (running)
    );

    ma_pc i_ma_pc (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus.addr),
        .pc_load  (pc_load),
        .pc_value (pc_value)
    );

    ac_link i_ac_link (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.alu)
    );

    core_mem i_core_mem (
        .clk         (clk),
        .bus         (bus.mem),
        .panel_addr  (panel_addr),
        .panel_we    (panel_we),
        .panel_wdata (panel_wdata),
        .panel_rdata (panel_rdata)
    );

    front_panel_apb i_front_panel (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .running     (running),
        .ac          (bus.ac),
        .link        (bus.link),
        .start       (start),
        .halt_req    (halt_req),
        .pc_load     (pc_load),
        .pc_value    (pc_value),
        .panel_addr  (panel_addr),
        .panel_we    (panel_we),
        .panel_wdata (panel_wdata),
        .panel_rdata (panel_rdata)
    );

endmodule

// File: tb/pdp8_props.sv
// APB and state sequencing checks
`timescale 1ns/1ps

module pdp8_props import pdp8_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   psel,
    input logic   penable,
    input state_t state,
    input logic   mem_we
);

    int error_count = 0;

    // a setup cycle is always followed by its access cycle.
    setup_then_access: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && !penable) |=> (psel && penable))
    else
    begin
        $error("APB access phase missing after setup");
        error_count++;
    end

    enable_needs_select: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
    else
    begin
        $error("penable high without psel");
        error_count++;
    end

    defer_after_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_defer) |-> ($past(state) == st_fetch))
    else
    begin
        $error("defer entered from a state other than fetch");
        error_count++;
    end

    no_write_halted: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_halt) |-> !mem_we)
    else
    begin
        $error("core memory write while halted");
        error_count++;
    end

endmodule

bind pdp8_top pdp8_props i_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .state   (bus.state),
    .mem_we  (bus.mem_we)
);

// File: tb/tb_pdp8.sv
// PDP-8 core testbench
`timescale 1ns/1ps

module tb_pdp8 import pdp8_pkg::*; ();

    localparam int half_period  = 20;
    localparam int num_programs = 20;
    localparam int max_instr    = 200;
    localparam int apb_cycles   = 900;
    localparam longint timeout_ns =
        longint'(2 * half_period) * (num_programs * (max_instr * 3 + apb_cycles) + 4000);

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] seed = 32'h1e0c_935f;
    word_t       model_mem [0:4095];
    word_t       stage_words [0:127];
    word_t       m_ac;
    logic        m_link;
    logic [31:0] rd;
    logic [31:0] r;
    logic        err;
    word_t       code_base;
    word_t       d1;
    word_t       a;
    word_t       w;
    int          n;

    pdp8_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(half_period) clk = ~clk;

    function automatic logic [31:0] rnd();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t mri(input logic [2:0] op, input logic ind, input logic pg,
                                  input int off);
        return {op, ind, pg, 7'(off)};
    endfunction

    // straight-line mix, so skips can only move forward.
    function automatic word_t random_instr();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [2:0]  op;
        logic [7:0]  micro;
        int          kind;
        r1 = rnd();
        r2 = rnd();
        kind = r1[31:16] % 7;
        if (kind == 6)
            return {op_opr, 1'b1, r2[31:27], 3'b000};
        if (kind >= 4)
        begin
            micro = r2[31:24] & 8'hFD;
            if (micro[3])
                micro[2] = 1'b0;
            return {op_opr, 1'b0, micro};
        end
        case (kind)
            0: op = op_and;
            1: op = op_tad;
            2: op = op_isz;
            default: op = op_dca;
        endcase
        // indirect goes through the pointer table in page zero.
        if (r2[15] && r2[14])
            return mri(op, 1'b1, 1'b0, 32 + r1[27:24]);
        else if (r2[13])
            return mri(op, 1'b0, 1'b0, 16 + r1[27:24]);
        else
            return mri(op, 1'b0, 1'b1, 96 + r1[27:24]);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected)
            report_failure($sformatf("FAIL %s: expected %0h, actual %0h",
                                     name, expected, actual));
    endtask

    task automatic apb_xfer(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(half_period / 2);
        rdata  = prdata;
        slverr = pslverr;
        check_eq("apb pready", 1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        slverr;
        apb_xfer(1'b1, addr, data, unused, slverr);
        check_eq("apb write error", 0, slverr);
    endtask

    task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
        logic slverr;
        apb_xfer(1'b0, addr, 32'd0, data, slverr);
        check_eq("apb read error", 0, slverr);
    endtask

    task automatic deposit_block(input word_t base, input int count);
        word_t addr;
        addr = base;
        reg_write(reg_addr, {20'b0, base});
        for (int i = 0; i < count; i++)
        begin
            reg_write(reg_data, {20'b0, stage_words[i]});
            model_mem[addr] = stage_words[i];
            addr = addr + 12'd1;
        end
    endtask

    task automatic examine(input word_t addr, output word_t data);
        logic [31:0] value;
        reg_write(reg_addr, {20'b0, addr});
        reg_read(reg_data, value);
        data = value[11:0];
    endtask

    task automatic run_dut(input word_t start_pc);
        logic [31:0] status;
        int          polls;
        polls = 0;
        reg_write(reg_addr, {20'b0, start_pc});
        reg_write(reg_ctrl, 32'd1);
        do
        begin
            reg_read(reg_ctrl, status);
            polls++;
            if (polls > max_instr * 3)
                report_failure("the program never halted");
        end
        while (status[0]);
    endtask

    // instruction-set model working on model_mem.
    task automatic run_model(input word_t start_pc);
        word_t       pc;
        word_t       instr;
        word_t       ea;
        logic [12:0] t;
        logic        cond;
        logic        done;
        int          steps;
        pc = start_pc;
        done = 1'b0;
        steps = 0;
        while (!done)
        begin
            instr = model_mem[pc];
            ea = instr[7] ? {pc[11:7], instr[6:0]} : {5'b0, instr[6:0]};
            pc = pc + 12'd1;
            if (instr[11:9] <= op_jmp && instr[8])
                ea = model_mem[ea];
            case (instr[11:9])
                op_and:
                    m_ac = m_ac & model_mem[ea];
                op_tad:
                    {m_link, m_ac} = {m_link, m_ac} + {1'b0, model_mem[ea]};
                op_isz:
                begin
                    model_mem[ea] = model_mem[ea] + 12'd1;
                    if (model_mem[ea] == 12'd0)
                        pc = pc + 12'd1;
                end
                op_dca:
                begin
                    model_mem[ea] = m_ac;
                    m_ac = 12'd0;
                end
                op_jms:
                begin
                    model_mem[ea] = pc;
                    pc = ea + 12'd1;
                end
                op_jmp:
                    pc = ea;
                op_opr:
                begin
                    if (!instr[8])
                    begin
                        if (instr[7])
                            m_ac = 12'd0;
                        if (instr[6])
                            m_link = 1'b0;
                        if (instr[5])
                            m_ac = ~m_ac;
                        if (instr[4])
                            m_link = ~m_link;
                        t = {m_link, m_ac};
                        if (instr[3])
                            t = {t[0], t[12:1]};
                        else if (instr[2])
                            t = {t[11:0], t[12]};
                        if (instr[0])
                            t = t + 13'd1;
                        {m_link, m_ac} = t;
                    end
                    else
                    begin
                        cond = (instr[6] && m_ac[11]) || (instr[5] && m_ac == 12'd0) ||
                               (instr[4] && m_link);
                        if (cond != instr[3])
                            pc = pc + 12'd1;
                        if (instr[7])
                            m_ac = 12'd0;
                        if (instr[1])
                            done = 1'b1;
                    end
                end
                default:
                    m_ac = m_ac;
            endcase
            steps++;
            if (steps > max_instr)
                report_failure("the model program ran away");
        end
    endtask

    initial
    begin
        #(timeout_ns);
        report_failure("watchdog expired before the tests finished");
    end

    initial
    begin
        wait (i_dut.i_props.error_count != 0);
        report_failure("a bound assertion failed");
    end

    initial
    begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'h0;
        pwdata  = 32'd0;
        m_ac    = 12'd0;
        m_link  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reg_read(reg_ctrl, rd);
        check_eq("reset ctrl", 0, rd);
        reg_read(reg_ac, rd);
        check_eq("reset ac", 0, rd);

        // deposit steps the address, examine needs a reload each time.
        r = rnd();
        code_base = r[31:20];
        for (int i = 0; i < 8; i++)
        begin
            r = rnd();
            stage_words[i] = r[31:20];
        end
        deposit_block(code_base, 8);
        for (int i = 0; i < 8; i++)
        begin
            examine(code_base + 12'(i), w);
            check_eq("deposit examine", stage_words[i], w);
        end

        // subroutine call and return through JMP I.
        stage_words[0] = 12'o7300;
        stage_words[1] = mri(op_tad, 1'b0, 1'b1, 100);
        stage_words[2] = mri(op_jms, 1'b0, 1'b1, 32);
        stage_words[3] = mri(op_dca, 1'b0, 1'b1, 101);
        stage_words[4] = 12'o7402;
        deposit_block(12'o1000, 5);
        stage_words[0] = 12'o0000;
        stage_words[1] = 12'o7001;
        stage_words[2] = mri(op_jmp, 1'b1, 1'b1, 32);
        deposit_block(12'o1040, 3);
        r = rnd();
        stage_words[0] = r[31:20];
        stage_words[1] = 12'o0000;
        deposit_block(12'o1144, 2);
        run_model(12'o1000);
        run_dut(12'o1000);
        reg_read(reg_ac, rd);
        check_eq("jms ac", {m_link, m_ac}, rd);
        examine(12'o1040, w);
        check_eq("jms return address", model_mem[12'o1040], w);
        examine(12'o1145, w);
        check_eq("jms result", model_mem[12'o1145], w);

        for (int p = 0; p < num_programs; p++)
        begin
            r = rnd();
            code_base = 12'((1 + r[31:16] % 30) * 128);
            d1 = code_base + 12'd96;
            for (int i = 0; i < 16; i++)
            begin
                r = rnd();
                stage_words[i] = (r[30:29] == 2'b00) ? 12'o7777 : r[31:20];
                r = rnd();
                stage_words[16 + i] = r[31] ? 12'd16 + {8'b0, r[27:24]}
                                            : d1 + {8'b0, r[27:24]};
            end
            deposit_block(12'd16, 32);
            for (int i = 0; i < 16; i++)
            begin
                r = rnd();
                stage_words[i] = (r[30:29] == 2'b00) ? 12'o7777 : r[31:20];
            end
            deposit_block(d1, 16);
            r = rnd();
            n = 20 + r[31:16] % 41;
            for (int i = 0; i < n; i++)
                stage_words[i] = random_instr();
            // a second HLT catches a skip over the first.
            stage_words[n] = 12'o7402;
            stage_words[n + 1] = 12'o7402;
            deposit_block(code_base, n + 2);
            run_model(code_base);
            run_dut(code_base);
            reg_read(reg_ac, rd);
            check_eq($sformatf("program %0d ac", p), {m_link, m_ac}, rd);
            for (int i = 0; i < 32; i++)
            begin
                a = (i < 16) ? 12'(16 + i) : d1 + 12'(i - 16);
                examine(a, w);
                check_eq($sformatf("program %0d data", p), model_mem[a], w);
            end
        end

        // endless IAC loop, stopped from the panel.
        stage_words[0] = 12'o7001;
        stage_words[1] = mri(op_jmp, 1'b0, 1'b1, 0);
        deposit_block(12'o2000, 2);
        reg_write(reg_addr, 32'o2000);
        reg_write(reg_ctrl, 32'd1);
        apb_xfer(1'b1, reg_data, 32'o1234, rd, err);
        check_eq("deposit while running error", 1, err);
        apb_xfer(1'b0, reg_data, 32'd0, rd, err);
        check_eq("examine while running error", 1, err);
        apb_xfer(1'b1, reg_addr, 32'o3000, rd, err);
        check_eq("address load while running error", 1, err);
        reg_write(reg_ctrl, 32'd2);
        reg_read(reg_ctrl, rd);
        check_eq("halt request", 0, rd);
        reg_read(reg_data, rd);
        check_eq("memory after refused deposit", 12'o7001, rd);

        if (i_dut.i_props.error_count != 0)
            report_failure("bound assertions reported errors");
        else
        begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: tb.f
verilog/pdp8_pkg.sv
verilog/core_bus_if.sv
verilog/state_machine.sv
verilog/ma_pc.sv
verilog/ac_link.sv
verilog/core_mem.sv
verilog/front_panel_apb.sv
verilog/pdp8_top.sv
tb/pdp8_props.sv
tb/tb_pdp8.sv

// File: Bender.yml
package:
  name: pdp8_panel

sources:
  - verilog/pdp8_pkg.sv
  - verilog/core_bus_if.sv
  - verilog/state_machine.sv
  - verilog/ma_pc.sv
  - verilog/ac_link.sv
  - verilog/core_mem.sv
  - verilog/front_panel_apb.sv
  - verilog/pdp8_top.sv
  - target: test
    files:
      - tb/pdp8_props.sv
      - tb/tb_pdp8.sv
